// ==== logic/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// base opcodes, RV32I
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_OP_IMM   7'b0010011
`define RV_OP_OP       7'b0110011
`define RV_OP_SYSTEM   7'b1110011

`define RV_RESET_PC    32'h0000_0000

// alu operation codes
`define RV_ALU_ADD      4'd0
`define RV_ALU_SUB      4'd1
`define RV_ALU_SLL      4'd2
`define RV_ALU_SLT      4'd3
`define RV_ALU_SLTU     4'd4
`define RV_ALU_XOR      4'd5
`define RV_ALU_SRL      4'd6
`define RV_ALU_SRA      4'd7
`define RV_ALU_OR       4'd8
`define RV_ALU_AND      4'd9
`define RV_ALU_PASS_IMM 4'd10
`define RV_ALU_PC_IMM   4'd11
`define RV_ALU_LINK     4'd12

`endif

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;

  // one instruction after decode
  typedef struct packed {
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  funct3;
    word_t       imm;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        is_load;
    logic        is_store;
    logic        writes_rd;
    logic        valid;
  } decoded_t;

  // request held on the memory port
  typedef struct packed {
    word_t       addr;
    word_t       wdata;
    logic [3:0]  wstrb;
    logic        instr;
  } mem_req_t;

  typedef enum logic [2:0] {
    FETCH,
    WAIT_FETCH,
    EXECUTE,
    REG_WRITE,
    CHECK_PC,
    FINISH_LOAD,
    FINISH_STORE,
    TRAP
  } cpu_state_t;

endpackage

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
  input  rv_pkg::word_t    instr,
  output rv_pkg::decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::word_t i_imm;
  rv_pkg::word_t s_imm;
  rv_pkg::word_t b_imm;
  rv_pkg::word_t u_imm;
  rv_pkg::word_t j_imm;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediate formats
  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.rd = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.funct3 = funct3;
    dec.alu_op = `RV_ALU_ADD;

    case (opcode)
      `RV_OP_LUI: begin
        dec.imm = u_imm;
        dec.alu_op = `RV_ALU_PASS_IMM;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
      end
      `RV_OP_AUIPC: begin
        dec.imm = u_imm;
        dec.alu_op = `RV_ALU_PC_IMM;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
      end
      `RV_OP_JAL: begin
        dec.imm = j_imm;
        dec.alu_op = `RV_ALU_LINK;
        dec.is_jal = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
      end
      `RV_OP_JALR: begin
        dec.imm = i_imm;
        dec.alu_op = `RV_ALU_LINK;
        dec.is_jalr = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = (funct3 == 3'b000);
      end
      `RV_OP_BRANCH: begin
        dec.rd = '0;
        dec.imm = b_imm;
        dec.is_branch = 1'b1;
        dec.valid = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      `RV_OP_LOAD: begin
        dec.imm = i_imm;
        dec.is_load = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010) ||
                    (funct3 == 3'b100) || (funct3 == 3'b101);
      end
      `RV_OP_STORE: begin
        dec.rd = '0;
        dec.imm = s_imm;
        dec.is_store = 1'b1;
        dec.valid = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
      end
      `RV_OP_OP_IMM: begin
        dec.imm = i_imm;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = `RV_ALU_ADD;
          3'b010: dec.alu_op = `RV_ALU_SLT;
          3'b011: dec.alu_op = `RV_ALU_SLTU;
          3'b100: dec.alu_op = `RV_ALU_XOR;
          3'b110: dec.alu_op = `RV_ALU_OR;
          3'b111: dec.alu_op = `RV_ALU_AND;
          3'b001: begin
            dec.alu_op = `RV_ALU_SLL;
            dec.valid = (funct7 == 7'b0000000);
          end
          default: begin
            // srli or srai, told apart by funct7
            dec.alu_op = funct7[5] ? `RV_ALU_SRA : `RV_ALU_SRL;
            dec.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      `RV_OP_OP: begin
        dec.writes_rd = 1'b1;
        dec.valid = (funct7 == 7'b0000000);
        case (funct3)
          3'b000: dec.alu_op = funct7[5] ? `RV_ALU_SUB : `RV_ALU_ADD;
          3'b001: dec.alu_op = `RV_ALU_SLL;
          3'b010: dec.alu_op = `RV_ALU_SLT;
          3'b011: dec.alu_op = `RV_ALU_SLTU;
          3'b100: dec.alu_op = `RV_ALU_XOR;
          3'b101: dec.alu_op = funct7[5] ? `RV_ALU_SRA : `RV_ALU_SRL;
          3'b110: dec.alu_op = `RV_ALU_OR;
          default: dec.alu_op = `RV_ALU_AND;
        endcase
        // only sub and sra take the alternate funct7
        if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          dec.valid = 1'b1;
        end
      end
      `RV_OP_SYSTEM: begin
        // ecall and ebreak run as no-ops
        dec.valid = 1'b1;
      end
      default: begin
        dec.valid = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_val,
  input  rv_pkg::word_t    rs2_val,
  input  rv_pkg::word_t    pc,
  output rv_pkg::word_t    result
);

  rv_pkg::word_t operand_b;
  logic [4:0]    shamt;
  logic          lt_signed;
  logic          lt_unsigned;

  // immediate forms take the shift amount from the immediate
  assign operand_b = dec.use_imm ? dec.imm : rs2_val;
  assign shamt = dec.use_imm ? dec.imm[4:0] : rs2_val[4:0];

  assign lt_signed = $signed(rs1_val) < $signed(operand_b);
  assign lt_unsigned = rs1_val < operand_b;

  always_comb begin
    case (dec.alu_op)
      `RV_ALU_ADD: begin
        result = rs1_val + operand_b;
      end
      `RV_ALU_SUB: begin
        result = rs1_val - operand_b;
      end
      `RV_ALU_SLL: begin
        result = rs1_val << shamt;
      end
      `RV_ALU_SLT: begin
        result = {31'b0, lt_signed};
      end
      `RV_ALU_SLTU: begin
        result = {31'b0, lt_unsigned};
      end
      `RV_ALU_XOR: begin
        result = rs1_val ^ operand_b;
      end
      `RV_ALU_SRL: begin
        result = rs1_val >> shamt;
      end
      `RV_ALU_SRA: begin
        result = $signed(rs1_val) >>> shamt;
      end
      `RV_ALU_OR: begin
        result = rs1_val | operand_b;
      end
      `RV_ALU_AND: begin
        result = rs1_val & operand_b;
      end
      `RV_ALU_PASS_IMM: begin
        result = dec.imm;
      end
      `RV_ALU_PC_IMM: begin
        result = pc + dec.imm;
      end
      `RV_ALU_LINK: begin
        // return address for jal and jalr
        result = pc + 32'd4;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== logic/rv_next_pc.sv ====
`timescale 1ns/1ps

module rv_next_pc (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_val,
  input  rv_pkg::word_t    rs2_val,
  input  rv_pkg::word_t    pc,
  output rv_pkg::word_t    next_pc,
  output rv_pkg::word_t    ls_addr,
  output logic             misaligned
);

  logic          taken;
  logic          redirect;
  rv_pkg::word_t pc_target;
  rv_pkg::word_t jalr_target;

  // branch condition from funct3
  always_comb begin
    case (dec.funct3)
      3'b000: taken = rs1_val == rs2_val;
      3'b001: taken = rs1_val != rs2_val;
      3'b100: taken = $signed(rs1_val) < $signed(rs2_val);
      3'b101: taken = $signed(rs1_val) >= $signed(rs2_val);
      3'b110: taken = rs1_val < rs2_val;
      3'b111: taken = rs1_val >= rs2_val;
      default: taken = 1'b0;
    endcase
  end

  assign pc_target = pc + dec.imm;
  assign jalr_target = (rs1_val + dec.imm) & 32'hffff_fffe;
  assign ls_addr = rs1_val + dec.imm;

  assign redirect = dec.is_jal || dec.is_jalr || (dec.is_branch && taken);

  always_comb begin
    if (dec.is_jalr) begin
      next_pc = jalr_target;
    end else if (dec.is_jal || (dec.is_branch && taken)) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // fall-through pc is always aligned
  assign misaligned = redirect && (next_pc[1:0] != 2'b00);

endmodule

// ==== logic/rv_cpu.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_cpu (
  input  logic          clk,
  input  logic          reset,
  output logic          mem_valid,
  output logic          mem_instr,
  input  logic          mem_ready,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output logic [3:0]    mem_wstrb,
  input  rv_pkg::word_t mem_rdata,
  output logic          trap
);

  rv_pkg::cpu_state_t state;
  rv_pkg::word_t      pc;
  rv_pkg::word_t      instr;
  rv_pkg::word_t      wb_data;
  logic               pc_misaligned;
  rv_pkg::mem_req_t   req;
  rv_pkg::word_t      regs [0:31];

  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_val;
  rv_pkg::word_t    rs2_val;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    next_pc;
  rv_pkg::word_t    ls_addr;
  logic             misaligned;
  logic             rf_we;
  rv_pkg::word_t    rf_wdata;

  function automatic rv_pkg::word_t load_ext(input rv_pkg::word_t raw,
                                             input logic [2:0] funct3);
    case (funct3)
      3'b000: load_ext = {{24{raw[7]}}, raw[7:0]};
      3'b001: load_ext = {{16{raw[15]}}, raw[15:0]};
      3'b100: load_ext = {24'b0, raw[7:0]};
      3'b101: load_ext = {16'b0, raw[15:0]};
      default: load_ext = raw;
    endcase
  endfunction

  // sub-word stores sit in the low lanes
  function automatic logic [3:0] store_strb(input logic [2:0] funct3);
    case (funct3)
      3'b000: store_strb = 4'b0001;
      3'b001: store_strb = 4'b0011;
      default: store_strb = 4'b1111;
    endcase
  endfunction

  rv_decode u_rv_decode (
    .instr (instr),
    .dec   (dec)
  );

  // x0 reads as zero
  assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

  rv_alu u_rv_alu (
    .dec     (dec),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .pc      (pc),
    .result  (alu_result)
  );

  rv_next_pc u_rv_next_pc (
    .dec        (dec),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .pc         (pc),
    .next_pc    (next_pc),
    .ls_addr    (ls_addr),
    .misaligned (misaligned)
  );

  assign mem_addr = req.addr;
  assign mem_wdata = req.wdata;
  assign mem_wstrb = req.wstrb;
  assign mem_instr = req.instr;

  // register file write port
  assign rf_we = (state == rv_pkg::REG_WRITE && dec.writes_rd) ||
                 (state == rv_pkg::FINISH_LOAD && mem_ready);
  assign rf_wdata = (state == rv_pkg::FINISH_LOAD) ? load_ext(mem_rdata, dec.funct3) : wb_data;

  always_ff @(posedge clk) begin
    if (rf_we && dec.rd != 5'd0) begin
      regs[dec.rd] <= rf_wdata;
    end
    if (state == rv_pkg::WAIT_FETCH && mem_ready) begin
      instr <= mem_rdata;
    end
    if (state == rv_pkg::EXECUTE) begin
      wb_data <= alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::FETCH;
      pc <= `RV_RESET_PC;
      pc_misaligned <= 1'b0;
      req <= '0;
      mem_valid <= 1'b0;
      trap <= 1'b0;
    end else begin
      case (state)
        rv_pkg::FETCH: begin
          req.addr <= pc;
          req.wstrb <= 4'b0000;
          req.instr <= 1'b1;
          mem_valid <= 1'b1;
          state <= rv_pkg::WAIT_FETCH;
        end
        rv_pkg::WAIT_FETCH: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= rv_pkg::EXECUTE;
          end
        end
        rv_pkg::EXECUTE: begin
          if (!dec.valid) begin
            state <= rv_pkg::TRAP;
          end else begin
            pc <= next_pc;
            pc_misaligned <= misaligned;
            if (dec.is_load) begin
              req.addr <= ls_addr;
              req.wstrb <= 4'b0000;
              req.instr <= 1'b0;
              mem_valid <= 1'b1;
              state <= rv_pkg::FINISH_LOAD;
            end else if (dec.is_store) begin
              req.addr <= ls_addr;
              req.wdata <= rs2_val;
              req.wstrb <= store_strb(dec.funct3);
              req.instr <= 1'b0;
              mem_valid <= 1'b1;
              state <= rv_pkg::FINISH_STORE;
            end else if (dec.is_branch) begin
              state <= rv_pkg::CHECK_PC;
            end else begin
              state <= rv_pkg::REG_WRITE;
            end
          end
        end
        rv_pkg::REG_WRITE: begin
          // jumps still need their target checked
          if (dec.is_jal || dec.is_jalr) begin
            state <= rv_pkg::CHECK_PC;
          end else begin
            state <= rv_pkg::FETCH;
          end
        end
        rv_pkg::CHECK_PC: begin
          state <= pc_misaligned ? rv_pkg::TRAP : rv_pkg::FETCH;
        end
        rv_pkg::FINISH_LOAD,
        rv_pkg::FINISH_STORE: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            req.wstrb <= 4'b0000;
            state <= rv_pkg::FETCH;
          end
        end
        default: begin
          // sticky until reset
          trap <= 1'b1;
        end
      endcase
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (mem_valid && !mem_ready) |=> (mem_valid && $stable(req)));

  a_trap_sticky: assert property (@(posedge clk)
    (trap && !reset) |=> trap);

  a_fetch_no_strb: assert property (@(posedge clk) disable iff (reset)
    mem_instr |-> (mem_wstrb == 4'b0000));

endmodule

// ==== verification/rv_tb.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_tb;

  localparam int NUM_PROGS = 44;
  localparam rv_pkg::word_t RESULT_BASE = 32'h0000_8000;

  logic          clk;
  logic          reset;
  logic          mem_valid;
  logic          mem_instr;
  logic          mem_ready;
  rv_pkg::word_t mem_addr;
  rv_pkg::word_t mem_wdata;
  logic [3:0]    mem_wstrb;
  rv_pkg::word_t mem_rdata;
  logic          trap;

  rv_pkg::word_t mem [0:16383];
  rv_pkg::word_t rng;
  rv_pkg::word_t wait_rng;
  rv_pkg::word_t wp;
  rv_pkg::word_t end_addr;
  int            wait_left;
  int            errors;
  int            checks;

  rv_pkg::word_t exp_addr [$];
  rv_pkg::word_t exp_val [$];
  logic [3:0]    exp_strb [$];
  rv_pkg::word_t obs_addr [$];
  rv_pkg::word_t obs_val [$];
  logic [3:0]    obs_strb [$];

  rv_cpu u_rv_cpu (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic rv_pkg::word_t xorshift(input rv_pkg::word_t x);
    rv_pkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic rv_pkg::word_t rand_next();
    rng = xorshift(rng);
    return rng;
  endfunction

  // expected values straight from the RV32I rules
  function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic rv_pkg::word_t ref_load_ext(input logic [2:0] f3, input rv_pkg::word_t w);
    case (f3)
      3'd0: return {{24{w[7]}}, w[7:0]};
      3'd1: return {{16{w[15]}}, w[15:0]};
      3'd4: return {24'b0, w[7:0]};
      3'd5: return {16'b0, w[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic logic ref_branch(input logic [2:0] f3, input rv_pkg::word_t a,
                                      input rv_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic rv_pkg::word_t lane_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  // instruction encoders
  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
      input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input rv_pkg::reg_addr_t rd,
      input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  task automatic check_word(input string name, input rv_pkg::word_t got,
                            input rv_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic emit(input rv_pkg::word_t w);
    mem[wp[15:2]] = w;
    wp = wp + 32'd4;
  endtask

  task automatic expect_store(input rv_pkg::word_t addr, input rv_pkg::word_t val,
                              input logic [3:0] strb);
    exp_addr.push_back(addr);
    exp_val.push_back(val);
    exp_strb.push_back(strb);
  endtask

  // lui plus addi, with the upper part rounded for the sign of the low part
  task automatic load_const(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t v);
    rv_pkg::word_t upper;
    upper = (v + 32'h800) >> 12;
    emit(enc_u(upper[19:0], rd, `RV_OP_LUI));
    emit(enc_i(v[11:0], rd, 3'd0, rd, `RV_OP_OP_IMM));
  endtask

  task automatic store_result(input rv_pkg::reg_addr_t rs, input rv_pkg::word_t exp);
    emit(enc_s(12'd0, rs, 5'd10, 3'd2));
    expect_store(RESULT_BASE, exp, 4'b1111);
  endtask

  // memory model with random wait states
  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    wait_left = -1;
    wait_rng = 32'h2bd0;
    for (int i = 0; i < 16384; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
    end
    forever begin
      @(posedge clk);
      #1;
      if (mem_ready) begin
        mem_ready = 1'b0;
        wait_left = -1;
      end else if (mem_valid) begin
        if (wait_left < 0) begin
          wait_rng = xorshift(wait_rng);
          wait_left = int'(wait_rng % 32'd4);
        end
        if (wait_left == 0) begin
          mem_rdata = mem[mem_addr[15:2]];
          if (mem_wstrb != 4'b0000) begin
            mem[mem_addr[15:2]] = (mem[mem_addr[15:2]] & ~lane_mask(mem_wstrb)) |
                                  (mem_wdata & lane_mask(mem_wstrb));
            if (mem_addr >= RESULT_BASE) begin
              obs_addr.push_back(mem_addr);
              obs_val.push_back(mem_wdata);
              obs_strb.push_back(mem_wstrb);
            end
          end
          mem_ready = 1'b1;
        end else begin
          wait_left--;
        end
      end else begin
        wait_left = -1;
      end
    end
  end

  // compare observed result stores against expectations
  always @(posedge clk) begin
    while (obs_addr.size() > 0) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("store to %h arrived with no expected value", obs_addr[0]);
      end else begin
        check_word("mem_addr", obs_addr[0], exp_addr[0]);
        check_strb("mem_wstrb", obs_strb[0], exp_strb[0]);
        check_word("mem_wdata", obs_val[0] & lane_mask(exp_strb[0]),
                   exp_val[0] & lane_mask(exp_strb[0]));
        void'(exp_addr.pop_front());
        void'(exp_val.pop_front());
        void'(exp_strb.pop_front());
      end
      void'(obs_addr.pop_front());
      void'(obs_val.pop_front());
      void'(obs_strb.pop_front());
    end
  end

  task automatic start_prog();
    @(posedge clk);
    #1;
    reset = 1'b1;
    exp_addr.delete();
    exp_val.delete();
    exp_strb.delete();
    wp = `RV_RESET_PC;
    // x10 points at the result region
    emit(enc_u(20'h8, 5'd10, `RV_OP_LUI));
  endtask

  task automatic release_reset();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    check_flag("mem_valid", mem_valid, 1'b0);
    check_flag("trap", trap, 1'b0);
    check_strb("mem_wstrb", mem_wstrb, 4'b0000);
    @(posedge clk);
    #1;
    check_flag("mem_valid", mem_valid, 1'b1);
    check_word("mem_addr", mem_addr, `RV_RESET_PC);
    check_flag("mem_instr", mem_instr, 1'b1);
    check_strb("mem_wstrb", mem_wstrb, 4'b0000);
  endtask

  task automatic run_prog(input string name);
    int n;
    end_addr = wp;
    emit(enc_j(21'd0, 5'd0));
    release_reset();
    n = 0;
    while (!(mem_valid && mem_instr && mem_addr == end_addr) && !trap && n < 2000) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (trap) begin
      errors++;
      $display("program %s raised an unexpected trap", name);
    end else if (n >= 2000) begin
      errors++;
      $display("program %s did not reach its final jump", name);
    end
    repeat (2) @(posedge clk);
    if (exp_addr.size() != 0) begin
      errors++;
      $display("program %s left %0d expected stores unseen", name, exp_addr.size());
    end
  endtask

  task automatic run_trap(input string name);
    int n;
    release_reset();
    n = 0;
    while (!trap && n < 500) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!trap) begin
      errors++;
      $display("program %s never raised trap", name);
    end else begin
      repeat (50) begin
        @(posedge clk);
        #1;
        check_flag("mem_valid", mem_valid, 1'b0);
        check_flag("trap", trap, 1'b1);
      end
    end
  endtask

  task automatic build_arith(input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t simm;
    rv_pkg::word_t sh;
    simm = {{20{b[11]}}, b[11:0]};
    sh = {27'b0, b[4:0]};
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
      store_result(5'd3, ref_alu(3'(f), 1'b0, a, b));
    end
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
    store_result(5'd3, ref_alu(3'd0, 1'b1, a, b));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
    store_result(5'd3, ref_alu(3'd5, 1'b1, a, b));
    for (int f = 0; f < 8; f++) begin
      if (f != 1 && f != 5) begin
        emit(enc_i(b[11:0], 5'd1, 3'(f), 5'd3, `RV_OP_OP_IMM));
        store_result(5'd3, ref_alu(3'(f), 1'b0, a, simm));
      end
    end
    emit(enc_i({7'h00, b[4:0]}, 5'd1, 3'd1, 5'd3, `RV_OP_OP_IMM));
    store_result(5'd3, ref_alu(3'd1, 1'b0, a, sh));
    emit(enc_i({7'h00, b[4:0]}, 5'd1, 3'd5, 5'd3, `RV_OP_OP_IMM));
    store_result(5'd3, ref_alu(3'd5, 1'b0, a, sh));
    emit(enc_i({7'h20, b[4:0]}, 5'd1, 3'd5, 5'd3, `RV_OP_OP_IMM));
    store_result(5'd3, ref_alu(3'd5, 1'b1, a, sh));
    // x0 stays zero
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    store_result(5'd0, 32'd0);
  endtask

  // marker 2 on the taken path, 1 on the fall-through
  task automatic add_branch(input logic [2:0] f3, input rv_pkg::word_t a,
                            input rv_pkg::word_t b);
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(enc_b(13'd12, 5'd2, 5'd1, f3));
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd3, `RV_OP_OP_IMM));
    emit(enc_j(21'd8, 5'd0));
    emit(enc_i(12'd2, 5'd0, 3'd0, 5'd3, `RV_OP_OP_IMM));
    store_result(5'd3, ref_branch(f3, a, b) ? 32'd2 : 32'd1);
  endtask

  initial begin
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t p;
    rv_pkg::word_t words [3];
    logic [2:0]    bf3 [6];
    logic [2:0]    lf3 [5];
    reset = 1'b1;
    rng = 32'h2bd0;
    errors = 0;
    checks = 0;
    words = '{32'h8081_f2c3, 32'h1234_5678, 32'hfedc_7a95};
    bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    lf3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

    for (int k = 0; k < 40; k++) begin
      start_prog();
      a = rand_next();
      b = rand_next();
      build_arith(a, b);
      run_prog("arith");
    end

    start_prog();
    for (int k = 0; k < 3; k++) begin
      mem[32'h1000 + k] = words[k];
    end
    emit(enc_u(20'h4, 5'd11, `RV_OP_LUI));
    for (int k = 0; k < 3; k++) begin
      for (int j = 0; j < 5; j++) begin
        emit(enc_i(12'(k * 4), 5'd11, lf3[j], 5'd3, `RV_OP_LOAD));
        store_result(5'd3, ref_load_ext(lf3[j], words[k]));
      end
    end
    load_const(5'd4, 32'hdead_beef);
    emit(enc_s(12'd1, 5'd4, 5'd10, 3'd0));
    expect_store(RESULT_BASE + 32'd1, 32'hdead_beef, 4'b0001);
    emit(enc_s(12'd2, 5'd4, 5'd10, 3'd1));
    expect_store(RESULT_BASE + 32'd2, 32'hdead_beef, 4'b0011);
    run_prog("load_store");

    start_prog();
    for (int k = 0; k < 6; k++) begin
      a = rand_next();
      b = rand_next();
      add_branch(bf3[k], a, b);
      add_branch(bf3[k], b, a);
      add_branch(bf3[k], a, a);
    end
    p = wp;
    emit(enc_j(21'd8, 5'd5));
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd0, `RV_OP_OP_IMM));
    store_result(5'd5, p + 32'd4);
    p = wp;
    emit(enc_u(20'h0, 5'd6, `RV_OP_AUIPC));
    emit(enc_i(12'd12, 5'd6, 3'd0, 5'd7, `RV_OP_JALR));
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd0, `RV_OP_OP_IMM));
    store_result(5'd7, p + 32'd8);
    run_prog("branch_jump");

    start_prog();
    emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, `RV_OP_OP_IMM));
    emit(32'h0000_007f);
    run_trap("bad_opcode");

    start_prog();
    emit(enc_i(12'h102, 5'd0, 3'd0, 5'd1, `RV_OP_OP_IMM));
    emit(enc_i(12'd0, 5'd1, 3'd0, 5'd0, `RV_OP_JALR));
    run_trap("misaligned_jalr");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(NUM_PROGS * 2000 * 10);
    $display("timeout after %0d programs worth of cycles", NUM_PROGS);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_alu.sv
logic/rv_next_pc.sv
logic/rv_cpu.sv
verification/rv_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module rv_tb -o rv_tb_sim

run: compile
	./obj_dir/rv_tb_sim | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
